// ==== bench/lsu_tb.sv ====
`timescale 1ns/10ps

module lsu_tb
    import lsu_pkg::*;
();

    localparam int    MAX_VEC  = 64;
    localparam int    VEC_COLS = 7;
    localparam addr_t MEM_BASE = 32'h8000_0000;
    localparam addr_t ERR_BASE = 32'h8fff_0000;

    logic     clk;
    logic     rst_n;
    logic     req_valid;
    lsu_req_t req;
    logic     busy;
    logic     done;
    lsu_rsp_t rsp;
    logic     aw_valid;
    logic     aw_ready;
    axi_ax_t  aw;
    logic     w_valid;
    logic     w_ready;
    axi_w_t   w;
    logic     b_valid;
    logic     b_ready;
    resp_t    b_resp;
    logic     ar_valid;
    logic     ar_ready;
    axi_ax_t  ar;
    logic     r_valid;
    logic     r_ready;
    axi_r_t   r;

    // slave memory and its bookkeeping
    word_t   mem [0:255];
    addr_t   wr_addr;
    addr_t   rd_addr;
    strb_t   last_strb;
    axsize_t last_size;
    int      aw_count;
    int      aw_dly;
    int      w_dly;
    int      b_dly;
    int      ar_dly;
    int      r_dly;
    logic    b_pend;
    logic    r_pend;
    int      seed;

    word_t  vec_mem [0:MAX_VEC*VEC_COLS-1];
    int     nvec;
    int     cycles;
    int     limit;
    mtime_t prev_mtime;
    logic   have_prev;

    lsu_top lsu_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .busy      (busy),
        .done      (done),
        .rsp       (rsp),
        .aw_valid  (aw_valid),
        .aw_ready  (aw_ready),
        .aw        (aw),
        .w_valid   (w_valid),
        .w_ready   (w_ready),
        .w         (w),
        .b_valid   (b_valid),
        .b_ready   (b_ready),
        .b_resp    (b_resp),
        .ar_valid  (ar_valid),
        .ar_ready  (ar_ready),
        .ar        (ar),
        .r_valid   (r_valid),
        .r_ready   (r_ready),
        .r         (r)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run();
        $display(">>> FAIL");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERROR %0t: %s = %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_err(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %0t: %s = %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_strb(input string name, input strb_t got, input strb_t exp);
        if (got !== exp) begin
            $display("ERROR %0t: %s = %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_size(input string name, input axsize_t got, input axsize_t exp);
        if (got !== exp) begin
            $display("ERROR %0t: %s = %0d, expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %0t: %s = %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_mtime(input string name, input mtime_t got,
                               input mtime_t lo, input mtime_t hi);
        if (got < lo || got > hi) begin
            $display("ERROR %0t: %s = %0d, expected %0d to %0d", $time, name, got, lo, hi);
            abort_run();
        end
    endtask

    function automatic logic in_mem(addr_t a);
        return a[31:10] == MEM_BASE[31:10];
    endfunction

    // byte lanes covered by an access of this size and alignment
    function automatic strb_t lane_strobe(width_e width, logic [1:0] ofs);
        int    n;
        int    first;
        strb_t s;
        case (width)
            WIDTH_BYTE: n = 1;
            WIDTH_HALF: n = 2;
            WIDTH_WORD: n = 4;
            default:    n = 0;
        endcase
        first = (n == 0) ? 0 : (int'(ofs) / n) * n;
        for (int i = 0; i < 4; i++) begin
            s[i] = (i >= first) && (i < first + n);
        end
        return s;
    endfunction

    // size code is log2 of the bytes in one beat
    function automatic axsize_t size_code(width_e width);
        int      bytes;
        axsize_t code;
        case (width)
            WIDTH_HALF: bytes = 2;
            WIDTH_WORD: bytes = 4;
            default:    bytes = 1;
        endcase
        code = '0;
        for (int i = 0; i < 3; i++) begin
            if ((1 << i) == bytes) code = axsize_t'(i);
        end
        return code;
    endfunction

    function automatic word_t merge_store(word_t old, lsu_req_t q);
        strb_t s;
        word_t lanes;
        word_t res;
        s     = lane_strobe(q.width, q.addr[1:0]);
        lanes = q.wdata << (8 * int'(q.addr[1:0]));
        res   = old;
        for (int i = 0; i < 4; i++) begin
            if (s[i]) res[8*i +: 8] = lanes[8*i +: 8];
        end
        return res;
    endfunction

    function automatic axi_r_t read_beat(addr_t a);
        axi_r_t beat;
        beat.resp = RESP_OKAY;
        beat.data = '0;
        if (a >= ERR_BASE) begin
            beat.resp = 2'd2;
        end else if (in_mem(a)) begin
            beat.data = mem[a[9:2]];
        end
        return beat;
    endfunction

    // 0 to 3 cycles of wait before a ready or a response
    task automatic pace_handshake(input logic pending, inout int dly, output logic go);
        go = 1'b0;
        if (pending) begin
            if (dly < 0) dly = int'($unsigned($random(seed)) % 32'd4);
            if (dly == 0) begin
                go  = 1'b1;
                dly = -1;
            end else begin
                dly = dly - 1;
            end
        end
    endtask

    // AXI slave with random ready and response delays
    // a raised ready or response valid drops at the next falling edge
    always @(negedge clk) begin
        logic go;
        if (!rst_n) begin
            aw_ready  = 1'b0;
            w_ready   = 1'b0;
            b_valid   = 1'b0;
            ar_ready  = 1'b0;
            r_valid   = 1'b0;
            b_pend    = 1'b0;
            r_pend    = 1'b0;
            aw_dly    = -1;
            w_dly     = -1;
            b_dly     = -1;
            ar_dly    = -1;
            r_dly     = -1;
            aw_count  = 0;
            last_strb = '0;
            last_size = '0;
            for (int i = 0; i < 256; i++) begin
                mem[i] = (MEM_BASE + (addr_t'(i) << 2)) ^ 32'h5a5a_5a5a;
            end
        end else begin
            if (aw_valid) aw_count = aw_count + 1;
            if (aw_ready) begin
                aw_ready = 1'b0;
            end else begin
                pace_handshake(aw_valid, aw_dly, go);
                if (go) begin
                    aw_ready  = 1'b1;
                    wr_addr   = aw.addr;
                    last_size = aw.size;
                end
            end
            if (w_ready) begin
                w_ready = 1'b0;
                b_pend  = 1'b1;
                b_resp  = (wr_addr >= ERR_BASE) ? 2'd2 : RESP_OKAY;
            end else begin
                pace_handshake(w_valid, w_dly, go);
                if (go) begin
                    w_ready   = 1'b1;
                    last_strb = w.strb;
                    for (int i = 0; i < 4; i++) begin
                        if (in_mem(wr_addr) && w.strb[i]) begin
                            mem[wr_addr[9:2]][8*i +: 8] = w.data[8*i +: 8];
                        end
                    end
                end
            end
            if (b_valid) begin
                b_valid = 1'b0;
            end else begin
                pace_handshake(b_pend, b_dly, go);
                if (go) begin
                    check_flag("b_ready", b_ready, 1'b1);
                    b_valid = 1'b1;
                    b_pend  = 1'b0;
                end
            end
            if (ar_ready) begin
                ar_ready = 1'b0;
                r_pend   = 1'b1;
            end else begin
                pace_handshake(ar_valid, ar_dly, go);
                if (go) begin
                    ar_ready  = 1'b1;
                    rd_addr   = ar.addr;
                    last_size = ar.size;
                end
            end
            if (r_valid) begin
                r_valid = 1'b0;
            end else begin
                pace_handshake(r_pend, r_dly, go);
                if (go) begin
                    check_flag("r_ready", r_ready, 1'b1);
                    r_valid = 1'b1;
                    r_pend  = 1'b0;
                    r       = read_beat(rd_addr);
                end
            end
        end
    end

    // cycle count in step with mtime
    always @(posedge clk) begin
        if (rst_n) begin
            cycles <= cycles + 1;
            if (cycles >= limit) begin
                $display("timeout: the vectors did not finish within %0d cycles", limit);
                abort_run();
            end
        end
    end

    task automatic run_vector(input int n);
        int       b;
        int       op;
        int       start;
        int       aw_before;
        lsu_req_t q;
        word_t    exp_rdata;
        logic     exp_err;
        logic     in_win;
        word_t    old_word;
        mtime_t   t;
        b           = n * VEC_COLS;
        op          = int'(vec_mem[b]);
        q.wen       = (op == 1);
        q.ren       = (op != 1);
        q.width     = width_e'(vec_mem[b+1][1:0]);
        q.sign      = vec_mem[b+2][0];
        q.addr      = vec_mem[b+3];
        q.wdata     = vec_mem[b+4];
        exp_rdata   = vec_mem[b+5];
        exp_err     = vec_mem[b+6][0];
        in_win      = (q.addr >= CLINT_BASE) && (q.addr <= CLINT_END);
        old_word    = in_mem(q.addr) ? mem[q.addr[9:2]] : '0;
        aw_before   = aw_count;
        start       = cycles;
        req         = q;
        req_valid   = 1'b1;
        @(negedge clk);
        req_valid = 1'b0;
        while (!done) begin
            check_flag("busy", busy, 1'b1);
            @(negedge clk);
        end
        check_flag("busy", busy, 1'b1);
        check_err("rsp.err", rsp.err, exp_err);
        if (op == 1) begin
            if (in_win) begin
                check_flag("aw_valid", logic'(aw_count != aw_before), 1'b0);
            end else begin
                check_strb("w.strb", last_strb, lane_strobe(q.width, q.addr[1:0]));
                check_size("aw.size", last_size, size_code(q.width));
            end
            if (in_mem(q.addr)) begin
                check_word("mem", mem[q.addr[9:2]], merge_store(old_word, q));
            end
        end else if (op == 2) begin
            if (!in_win) begin
                check_size("ar.size", last_size, size_code(q.width));
            end
            check_word("rsp.rdata", rsp.rdata, exp_rdata);
        end else begin
            t = {32'h0, rsp.rdata};
            check_mtime("mtime", t, mtime_t'(start), mtime_t'(cycles));
            if (have_prev) begin
                check_mtime("mtime order", t, prev_mtime + 64'd1, mtime_t'(cycles));
            end
            prev_mtime = t;
            have_prev  = 1'b1;
        end
        @(negedge clk);
    endtask

    initial begin
        req_valid  = 1'b0;
        req        = '0;
        rst_n      = 1'b0;
        aw_ready   = 1'b0;
        w_ready    = 1'b0;
        b_valid    = 1'b0;
        b_resp     = RESP_OKAY;
        ar_ready   = 1'b0;
        r_valid    = 1'b0;
        r          = '0;
        seed       = 32'h51191208;
        nvec       = 0;
        have_prev  = 1'b0;
        prev_mtime = '0;
        for (int i = 0; i < MAX_VEC * VEC_COLS; i++) begin
            vec_mem[i] = '0;
        end
        $readmemh("bench/lsu_vectors.txt", vec_mem);
        // an operation code of zero ends the list
        while (nvec < MAX_VEC && vec_mem[nvec * VEC_COLS] != 32'h0) begin
            nvec = nvec + 1;
        end
        limit = nvec * 20 + 100;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_flag("aw_valid", aw_valid, 1'b0);
        check_flag("w_valid", w_valid, 1'b0);
        check_flag("ar_valid", ar_valid, 1'b0);
        check_flag("b_ready", b_ready, 1'b0);
        check_flag("r_ready", r_ready, 1'b0);
        check_flag("done", done, 1'b0);
        check_flag("busy", busy, 1'b0);
        if (nvec == 0) begin
            $display("no vectors were read from bench/lsu_vectors.txt");
            abort_run();
        end
        for (int n = 0; n < nvec; n++) begin
            run_vector(n);
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== bench/lsu_vectors.txt ====
// op width sign addr wdata exp_rdata exp_err, all hex
// op 1 store, 2 load, 3 timer low word load, 0 ends the list; width 1 byte, 2 half, 3 word
1 3 0 80000000 12345678 00000000 0
2 3 0 80000000 00000000 12345678 0
1 3 0 80000004 a1b2c3d4 00000000 0
2 3 0 80000004 00000000 a1b2c3d4 0
// byte stores at each offset
1 3 0 80000020 00000000 00000000 0
1 1 0 80000020 000000aa 00000000 0
2 3 0 80000020 00000000 000000aa 0
1 1 0 80000021 555555bb 00000000 0
2 3 0 80000020 00000000 0000bbaa 0
1 1 0 80000022 000000cc 00000000 0
1 1 0 80000023 000000dd 00000000 0
2 3 0 80000020 00000000 ddccbbaa 0
// half stores
1 3 0 80000030 11111111 00000000 0
1 2 0 80000030 0000beef 00000000 0
2 3 0 80000030 00000000 1111beef 0
1 2 0 80000032 77778001 00000000 0
2 3 0 80000030 00000000 8001beef 0
// signed and unsigned loads
1 3 0 80000040 34807f12 00000000 0
2 1 1 80000020 00000000 ffffffaa 0
2 1 0 80000020 00000000 000000aa 0
2 1 1 80000023 00000000 ffffffdd 0
2 1 1 80000041 00000000 0000007f 0
2 1 1 80000042 00000000 ffffff80 0
2 1 0 80000042 00000000 00000080 0
2 2 1 80000030 00000000 ffffbeef 0
2 2 0 80000030 00000000 0000beef 0
2 2 1 80000032 00000000 ffff8001 0
2 2 0 80000032 00000000 00008001 0
2 2 1 80000042 00000000 00003480 0
// timer
3 3 0 a0000048 00000000 00000000 0
3 3 0 a0000048 00000000 00000000 0
2 3 0 a000004c 00000000 00000000 0
// error cases
1 3 0 a0000048 deadbeef 00000000 1
1 1 0 a000004c 000000ff 00000000 1
1 3 0 8fff0000 cafef00d 00000000 1
2 3 0 8fff0004 00000000 00000000 1
2 1 1 90000000 00000000 00000000 1
2 3 0 80000000 00000000 12345678 0
0 0 0 00000000 00000000 00000000 0

// ==== design/clint_timer.sv ====
`timescale 1ns/10ps

module clint_timer
    import lsu_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    rd_valid,
    input  dev_rd_t rd,
    output logic    rd_ready,
    output logic    rd_rvalid,
    output word_t   rd_data
);

    mtime_t mtime;
    word_t  data_q;
    logic   rvalid_q;
    logic   rd_fire;

    // no wait states on the read port
    assign rd_ready = 1'b1;
    assign rd_fire  = rd_valid & rd_ready;

    // free-running machine timer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime <= '0;
        end else begin
            mtime <= mtime + 64'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= rd_fire;
        end
    end

    // snapshot taken in the acceptance cycle, bit 2 picks the half
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            data_q <= rd.addr[2] ? mtime[63:32] : mtime[31:0];
        end
    end

    assign rd_rvalid = rvalid_q;
    assign rd_data   = data_q;

endmodule

// ==== design/load_extract.sv ====
`timescale 1ns/10ps

module load_extract
    import lsu_pkg::*;
(
    input  word_t    raw,
    input  lsu_req_t req,
    input  logic     err,
    output word_t    rdata
);

    word_t shifted;
    logic  fill;

    // bring the addressed lane down to bit 0
    assign shifted = raw >> {req.addr[1:0], 3'b000};

    always_comb begin
        fill = 1'b0;
        case (req.width)
            WIDTH_BYTE: begin
                fill  = req.sign & shifted[7];
                rdata = {{24{fill}}, shifted[7:0]};
            end
            WIDTH_HALF: begin
                fill  = req.sign & shifted[15];
                rdata = {{16{fill}}, shifted[15:0]};
            end
            WIDTH_WORD: rdata = shifted;
            default:    rdata = '0;
        endcase
        // failed access returns zero
        if (err) rdata = '0;
    end

endmodule

// ==== design/lsu_ctrl.sv ====
`timescale 1ns/10ps

module lsu_ctrl
    import lsu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     req_valid,
    input  lsu_req_t req,
    input  axi_w_t   lane_w,
    input  axsize_t  lane_size,
    output logic     busy,
    output logic     done,
    output logic     rsp_err,
    output word_t    raw_rdata,
    output lsu_req_t cur_req,
    output logic     aw_valid,
    input  logic     aw_ready,
    output axi_ax_t  aw,
    output logic     w_valid,
    input  logic     w_ready,
    output axi_w_t   w,
    input  logic     b_valid,
    output logic     b_ready,
    input  resp_t    b_resp,
    output logic     ar_valid,
    input  logic     ar_ready,
    output axi_ax_t  ar,
    input  logic     r_valid,
    output logic     r_ready,
    input  axi_r_t   r,
    output logic     dev_rd_valid,
    input  logic     dev_rd_ready,
    output dev_rd_t  dev_rd,
    input  logic     dev_rd_rvalid,
    input  word_t    dev_rd_data
);

    lsu_state_e state;
    lsu_req_t   req_q;
    word_t      raw_q;
    logic       err_q;
    // timer read accepted, waiting for its data beat
    logic       dev_wait;

    function automatic logic in_clint(addr_t a);
        return (a >= CLINT_BASE) && (a <= CLINT_END);
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            err_q    <= 1'b0;
            dev_wait <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (req_valid) begin
                        err_q <= 1'b0;
                        if (req.wen) begin
                            // timer window is read only
                            if (in_clint(req.addr)) begin
                                state <= DONE;
                                err_q <= 1'b1;
                            end else begin
                                state <= WR_ADDR;
                            end
                        end else if (req.ren) begin
                            state <= in_clint(req.addr) ? DEV_RD : RD_ADDR;
                        end else begin
                            state <= DONE;
                        end
                    end
                end
                RD_ADDR: begin
                    if (ar_ready) state <= RD_DATA;
                end
                RD_DATA: begin
                    if (r_valid) begin
                        err_q <= (r.resp != RESP_OKAY);
                        state <= DONE;
                    end
                end
                WR_ADDR: begin
                    if (aw_ready) state <= WR_DATA;
                end
                WR_DATA: begin
                    if (w_ready) state <= WR_RESP;
                end
                WR_RESP: begin
                    if (b_valid) begin
                        err_q <= (b_resp != RESP_OKAY);
                        state <= DONE;
                    end
                end
                DEV_RD: begin
                    if (!dev_wait) begin
                        if (dev_rd_ready) dev_wait <= 1'b1;
                    end else if (dev_rd_rvalid) begin
                        dev_wait <= 1'b0;
                        state    <= DONE;
                    end
                end
                DONE:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // request and read word capture
    always_ff @(posedge clk) begin
        if (state == IDLE && req_valid) begin
            req_q <= req;
            raw_q <= '0;
        end else if (state == RD_DATA && r_valid) begin
            raw_q <= r.data;
        end else if (state == DEV_RD && dev_wait && dev_rd_rvalid) begin
            raw_q <= dev_rd_data;
        end
    end

    assign busy    = (state != IDLE);
    assign done    = (state == DONE);
    assign rsp_err = err_q;

    assign raw_rdata = raw_q;
    assign cur_req   = req_q;

    // handshake strobes straight from the state
    assign ar_valid     = (state == RD_ADDR);
    assign r_ready      = (state == RD_DATA);
    assign aw_valid     = (state == WR_ADDR);
    assign w_valid      = (state == WR_DATA);
    assign b_ready      = (state == WR_RESP);
    assign dev_rd_valid = (state == DEV_RD) && !dev_wait;

    // payloads follow the latched request, stable under back-pressure
    assign aw     = '{addr: req_q.addr, size: lane_size};
    assign ar     = '{addr: req_q.addr, size: lane_size};
    assign w      = lane_w;
    assign dev_rd = '{addr: req_q.addr};

endmodule

// ==== design/lsu_pkg.sv ====
package lsu_pkg;

    // plain vector types
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;
    typedef logic [2:0]  axsize_t;
    typedef logic [1:0]  resp_t;
    typedef logic [63:0] mtime_t;

    // access width, same codes as the core mask field
    typedef enum logic [1:0] {
        WIDTH_NONE = 2'd0,
        WIDTH_BYTE = 2'd1,
        WIDTH_HALF = 2'd2,
        WIDTH_WORD = 2'd3
    } width_e;

    typedef enum logic [2:0] {
        IDLE,
        RD_ADDR,
        RD_DATA,
        WR_ADDR,
        WR_DATA,
        WR_RESP,
        DEV_RD,
        DONE
    } lsu_state_e;

    // core request
    typedef struct packed {
        logic   wen;
        logic   ren;
        logic   sign;
        width_e width;
        addr_t  addr;
        word_t  wdata;
    } lsu_req_t;

    typedef struct packed {
        word_t rdata;
        logic  err;
    } lsu_rsp_t;

    // aw / ar payload
    typedef struct packed {
        addr_t   addr;
        axsize_t size;
    } axi_ax_t;

    typedef struct packed {
        word_t data;
        strb_t strb;
    } axi_w_t;

    typedef struct packed {
        word_t data;
        resp_t resp;
    } axi_r_t;

    typedef struct packed {
        addr_t addr;
    } dev_rd_t;

    // timer window, low word at base and high word at base+4
    localparam addr_t CLINT_BASE = 32'ha000_0048;
    localparam addr_t CLINT_END  = 32'ha000_004f;

    localparam resp_t RESP_OKAY = 2'd0;

endpackage

// ==== design/lsu_top.sv ====
`timescale 1ns/10ps

module lsu_top
    import lsu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     req_valid,
    input  lsu_req_t req,
    output logic     busy,
    output logic     done,
    output lsu_rsp_t rsp,
    output logic     aw_valid,
    input  logic     aw_ready,
    output axi_ax_t  aw,
    output logic     w_valid,
    input  logic     w_ready,
    output axi_w_t   w,
    input  logic     b_valid,
    output logic     b_ready,
    input  resp_t    b_resp,
    output logic     ar_valid,
    input  logic     ar_ready,
    output axi_ax_t  ar,
    input  logic     r_valid,
    output logic     r_ready,
    input  axi_r_t   r
);

    lsu_req_t cur_req;
    axi_w_t   lane_w;
    axsize_t  lane_size;
    word_t    raw_rdata;

    // timer read port
    logic     dev_rd_valid;
    logic     dev_rd_ready;
    dev_rd_t  dev_rd;
    logic     dev_rd_rvalid;
    word_t    dev_rd_data;

    lsu_ctrl lsu_ctrl_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .req           (req),
        .lane_w        (lane_w),
        .lane_size     (lane_size),
        .busy          (busy),
        .done          (done),
        .rsp_err       (rsp.err),
        .raw_rdata     (raw_rdata),
        .cur_req       (cur_req),
        .aw_valid      (aw_valid),
        .aw_ready      (aw_ready),
        .aw            (aw),
        .w_valid       (w_valid),
        .w_ready       (w_ready),
        .w             (w),
        .b_valid       (b_valid),
        .b_ready       (b_ready),
        .b_resp        (b_resp),
        .ar_valid      (ar_valid),
        .ar_ready      (ar_ready),
        .ar            (ar),
        .r_valid       (r_valid),
        .r_ready       (r_ready),
        .r             (r),
        .dev_rd_valid  (dev_rd_valid),
        .dev_rd_ready  (dev_rd_ready),
        .dev_rd        (dev_rd),
        .dev_rd_rvalid (dev_rd_rvalid),
        .dev_rd_data   (dev_rd_data)
    );

    // lane handling works on the latched request
    store_align store_align_inst (
        .req       (cur_req),
        .lane_w    (lane_w),
        .lane_size (lane_size)
    );

    load_extract load_extract_inst (
        .raw   (raw_rdata),
        .req   (cur_req),
        .err   (rsp.err),
        .rdata (rsp.rdata)
    );

    clint_timer clint_timer_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_valid  (dev_rd_valid),
        .rd        (dev_rd),
        .rd_ready  (dev_rd_ready),
        .rd_rvalid (dev_rd_rvalid),
        .rd_data   (dev_rd_data)
    );

endmodule

// ==== design/store_align.sv ====
`timescale 1ns/10ps

module store_align
    import lsu_pkg::*;
(
    input  lsu_req_t req,
    output axi_w_t   lane_w,
    output axsize_t  lane_size
);

    logic [1:0] ofs;

    assign ofs = req.addr[1:0];

    // move store data up to its byte lane
    assign lane_w.data = req.wdata << {ofs, 3'b000};

    always_comb begin
        case (req.width)
            WIDTH_BYTE: lane_w.strb = strb_t'(4'b0001 << ofs);
            WIDTH_HALF: lane_w.strb = ofs[1] ? 4'b1100 : 4'b0011;
            WIDTH_WORD: lane_w.strb = 4'b1111;
            default:    lane_w.strb = 4'b0000;
        endcase
    end

    // AXI size code: bytes per beat as log2
    always_comb begin
        case (req.width)
            WIDTH_HALF: lane_size = 3'd1;
            WIDTH_WORD: lane_size = 3'd2;
            default:    lane_size = 3'd0;
        endcase
    end

endmodule

// ==== files.f ====
design/lsu_pkg.sv
design/store_align.sv
design/load_extract.sv
design/clint_timer.sv
design/lsu_ctrl.sv
design/lsu_top.sv
bench/lsu_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the LSU testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --top-module lsu_tb -f files.f
./obj_dir/Vlsu_tb 2>&1 | tee sim.log

if grep -q '>>> FAIL' sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q '>>> PASS' sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
